/* src/hawk_pkg.sv */
/*
 * hawk shared definitions
 * word and address widths, region bases, controller states
 * and the two decodings of a dram word
 */
package hawk_pkg;

    // dram geometry
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // region bases, word addresses
    localparam logic [ADDR_W-1:0] ATT_BASE  = 16'h0000;
    localparam logic [ADDR_W-1:0] LIST_BASE = 16'h0100;

    // control unit states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACTIVE = 2'd1,
        DRAIN  = 2'd2
    } hawk_state_e;

    // att entry view
    typedef struct packed {
        logic        valid;
        logic [14:0] rsvd;
        logic [15:0] page_idx;
    } hawk_att_t;

    // free list entry view
    typedef struct packed {
        logic        last;
        logic [14:0] rsvd;
        logic [15:0] next_ptr;
    } hawk_list_t;

    // one dram word, read as att or list entry by region
    typedef union packed {
        hawk_att_t  att;
        hawk_list_t lst;
    } hawk_word_u;

endpackage

/* src/hawk_ctrl_unit.sv */
/*
 * hawk control unit
 * boot order for att and free list init, cpu hold,
 * and free list rebuild with cpu drain
 */
`timescale 1ns/1ns

module hawk_ctrl_unit
    import hawk_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    // page writer status
    input  logic init_att_done,
    input  logic init_list_done,
    // cpu side
    input  logic cpu_vld_access,
    input  logic rebuild_req,
    // page writer control
    output logic init_att,
    output logic init_list,
    output logic hold_hwk_wr,
    // cpu gate control
    output logic hold_cpu
);

    hawk_state_e p_state;
    hawk_state_e n_state;
    logic        n_init_att;
    logic        n_init_list;
    logic        n_hold_hwk_wr;
    logic        n_hold_cpu;

    //////////////////////////////
    // state and output registers
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            p_state     <= IDLE;
            // cpu kept off dram until both regions are built
            hold_cpu    <= 1'b1;
            init_att    <= 1'b1;
            init_list   <= 1'b1;
            hold_hwk_wr <= 1'b0;
        end else begin
            p_state     <= n_state;
            hold_cpu    <= n_hold_cpu;
            init_att    <= n_init_att;
            init_list   <= n_init_list;
            hold_hwk_wr <= n_hold_hwk_wr;
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        n_state       = p_state;
        n_init_att    = init_att;
        n_init_list   = init_list;
        n_hold_hwk_wr = hold_hwk_wr;
        n_hold_cpu    = hold_cpu;

        case (p_state)
            IDLE: begin
                // att first, list follows on the next cycle
                if (init_att_done) begin
                    n_init_att = 1'b0;
                end
                if (init_list_done) begin
                    n_init_list = 1'b0;
                    n_hold_cpu  = 1'b0;
                    n_state     = ACTIVE;
                end
            end
            ACTIVE: begin
                // rebuild only honored here
                if (rebuild_req) begin
                    n_hold_cpu = 1'b1;
                    n_state    = DRAIN;
                end
            end
            DRAIN: begin
                if (init_list_done) begin
                    // list rebuilt, hand port back to cpu
                    n_init_list   = 1'b0;
                    n_hold_cpu    = 1'b0;
                    n_hold_hwk_wr = 1'b0;
                    n_state       = ACTIVE;
                end else begin
                    // stall writer while a cpu write is still landing
                    n_hold_hwk_wr = cpu_vld_access;
                    if (!cpu_vld_access) begin
                        n_init_list = 1'b1;
                    end
                end
            end
            default: begin
                n_state = IDLE;
            end
        endcase
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // writer never owns the port while cpu is released
    a_hold_during_init: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (init_att || init_list) |-> hold_cpu
    );

    // stray rebuild outside active is ignored
    a_rebuild_ignored: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (rebuild_req && p_state != ACTIVE && !init_list_done)
            |=> (p_state == $past(p_state)) && (hold_cpu == $past(hold_cpu))
    );

endmodule

/* src/hawk_pg_writer.sv */
/*
 * hawk page writer
 * walks the att region, then the free list region,
 * writing one initial word per unstalled cycle
 */
`timescale 1ns/1ns

module hawk_pg_writer
    import hawk_pkg::*;
#(
    parameter int ATT_ENTRIES  = 16,
    parameter int LIST_ENTRIES = 8
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // control unit levels
    input  logic              init_att,
    input  logic              init_list,
    input  logic              hold_hwk_wr,
    // region complete pulse on the final write
    output logic              init_att_done,
    output logic              init_list_done,
    // dram write request
    output logic              pg_we,
    output logic [ADDR_W-1:0] pg_addr,
    output logic [DATA_W-1:0] pg_wdata
);

    // last entry index of each region
    localparam logic [ADDR_W-1:0] ATT_LAST  = ADDR_W'(ATT_ENTRIES - 1);
    localparam logic [ADDR_W-1:0] LIST_LAST = ADDR_W'(LIST_ENTRIES - 1);

    logic [ADDR_W-1:0] cnt;
    logic              att_sel;
    logic              list_sel;
    logic              cnt_last;
    hawk_word_u        word;

    //////////////////////////////
    // region select
    //////////////////////////////

    // att has priority over list
    // list runs only once init_att drops
    assign att_sel  = init_att;
    assign list_sel = !init_att && init_list;

    // final entry of whichever region is active
    always_comb begin
        cnt_last = 1'b0;
        if (att_sel) begin
            cnt_last = (cnt == ATT_LAST);
        end else if (list_sel) begin
            cnt_last = (cnt == LIST_LAST);
        end
    end

    // one write per cycle unless stalled
    assign pg_we = (att_sel || list_sel) && !hold_hwk_wr;

    assign init_att_done  = pg_we && att_sel && cnt_last;
    assign init_list_done = pg_we && list_sel && cnt_last;

    //////////////////////////////
    // entry counter
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt <= '0;
        end else if (!att_sel && !list_sel) begin
            // park at the first entry while idle
            cnt <= '0;
        end else if (pg_we) begin
            // wrap between regions
            if (cnt_last) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + ADDR_W'(1);
            end
        end
    end

    //////////////////////////////
    // address and word builder
    //////////////////////////////

    assign pg_addr = (att_sel ? ATT_BASE : LIST_BASE) + cnt;

    always_comb begin
        word = '0;
        if (att_sel) begin
            // att entries start invalid with no page mapped
            word.att.valid    = 1'b0;
            word.att.page_idx = '0;
        end else begin
            // each free page links to its successor
            word.lst.next_ptr = cnt + ADDR_W'(1);
            word.lst.last     = (cnt == LIST_LAST);
        end
    end

    assign pg_wdata = word;

    //////////////////////////////
    // checks
    //////////////////////////////

    // no write while the control unit stalls us
    a_no_we_on_hold: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        hold_hwk_wr |-> !pg_we
    );

endmodule

/* src/hawk_cpu_gate.sv */
/*
 * hawk cpu gate
 * grants cpu writes when not held and muxes the single
 * dram write port between cpu and page writer
 */
`timescale 1ns/1ns

module hawk_cpu_gate
    import hawk_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    // control unit
    input  logic              hold_cpu,
    // cpu write request
    input  logic              cpu_req,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_wdata,
    // page writer request
    input  logic              pg_we,
    input  logic [ADDR_W-1:0] pg_addr,
    input  logic [DATA_W-1:0] pg_wdata,
    // cpu response
    output logic              cpu_gnt,
    output logic              cpu_vld_access,
    // dram write port
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata
);

    logic cpu_wr;

    //////////////////////////////
    // grant
    //////////////////////////////

    // same-cycle grant, cpu holds request until then
    assign cpu_gnt = cpu_req && !hold_cpu;
    assign cpu_wr  = cpu_req && cpu_gnt;

    // completed write, seen by ctrl one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cpu_vld_access <= 1'b0;
        end else begin
            cpu_vld_access <= cpu_wr;
        end
    end

    //////////////////////////////
    // port mux
    //////////////////////////////

    always_comb begin
        if (hold_cpu) begin
            // writer owns the port
            mem_we    = pg_we;
            mem_addr  = pg_addr;
            mem_wdata = pg_wdata;
        end else begin
            mem_we    = cpu_wr;
            mem_addr  = cpu_addr;
            mem_wdata = cpu_wdata;
        end
    end

    // writer and cpu never collide on the port
    a_port_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(pg_we && cpu_wr)
    );

endmodule

/* src/hawk_top.sv */
/*
 * hawk boot and maintenance path
 * control unit, page writer and cpu gate on one dram write port
 */
`timescale 1ns/1ns

module hawk_top
    import hawk_pkg::*;
#(
    parameter int ATT_ENTRIES  = 16,
    parameter int LIST_ENTRIES = 8
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // maintenance
    input  logic              rebuild_req,
    // cpu write port
    input  logic              cpu_req,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_wdata,
    output logic              cpu_gnt,
    // dram write port
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata
);

    // ctrl to writer
    logic init_att;
    logic init_list;
    logic hold_hwk_wr;
    logic init_att_done;
    logic init_list_done;

    // ctrl to gate
    logic hold_cpu;
    logic cpu_vld_access;

    // writer to gate
    logic              pg_we;
    logic [ADDR_W-1:0] pg_addr;
    logic [DATA_W-1:0] pg_wdata;

    //////////////////////////////
    // control unit
    //////////////////////////////

    hawk_ctrl_unit u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_att_done  (init_att_done),
        .init_list_done (init_list_done),
        .cpu_vld_access (cpu_vld_access),
        .rebuild_req    (rebuild_req),
        .init_att       (init_att),
        .init_list      (init_list),
        .hold_hwk_wr    (hold_hwk_wr),
        .hold_cpu       (hold_cpu)
    );

    //////////////////////////////
    // page writer
    //////////////////////////////

    hawk_pg_writer #(
        .ATT_ENTRIES  (ATT_ENTRIES),
        .LIST_ENTRIES (LIST_ENTRIES)
    ) u_pg_writer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_att       (init_att),
        .init_list      (init_list),
        .hold_hwk_wr    (hold_hwk_wr),
        .init_att_done  (init_att_done),
        .init_list_done (init_list_done),
        .pg_we          (pg_we),
        .pg_addr        (pg_addr),
        .pg_wdata       (pg_wdata)
    );

    //////////////////////////////
    // cpu gate
    //////////////////////////////

    hawk_cpu_gate u_cpu_gate (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .hold_cpu       (hold_cpu),
        .cpu_req        (cpu_req),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .pg_we          (pg_we),
        .pg_addr        (pg_addr),
        .pg_wdata       (pg_wdata),
        .cpu_gnt        (cpu_gnt),
        .cpu_vld_access (cpu_vld_access),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

endmodule

/* bench/hawk_checker.sv */
/*
 * hawk dram port checker
 * shadows every dram write, compares page writer words with the
 * expected init image and cpu writes with the posted queue
 */
`timescale 1ns/1ns

module hawk_checker
    import hawk_pkg::*;
#(
    parameter int ATT_ENTRIES  = 16,
    parameter int LIST_ENTRIES = 8
) (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              cpu_req,
    input logic              cpu_gnt,
    input logic              mem_we,
    input logic [ADDR_W-1:0] mem_addr,
    input logic [DATA_W-1:0] mem_wdata
);

    // posted cpu writes, {addr, data}, oldest first
    logic [ADDR_W+DATA_W-1:0] cpu_q[$];
    // last value written to every dram word
    logic [DATA_W-1:0]        shadow [2**ADDR_W];
    int                       att_hits [ATT_ENTRIES];
    int                       list_hits [LIST_ENTRIES];
    int                       att_wr_cnt  = 0;
    int                       list_wr_cnt = 0;
    int                       cpu_wr_cnt  = 0;
    int                       err_cnt     = 0;

    // att words all zero, list word idx links to idx+1, last on the final one
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        hawk_word_u w;
        int         idx;
        w   = '0;
        idx = int'(addr) - int'(LIST_BASE);
        if (idx >= 0 && idx < LIST_ENTRIES) begin
            w.lst.next_ptr = ADDR_W'(idx + 1);
            w.lst.last     = (idx == LIST_ENTRIES - 1);
        end
        return w;
    endfunction

    task automatic log_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic post_cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        cpu_q.push_back({addr, data});
    endtask

    task automatic flush_cpu();
        cpu_q.delete();
    endtask

    function automatic int pending();
        return cpu_q.size();
    endfunction

    // new fill phase, shadow contents kept
    task automatic clear_counts();
        int i;
        for (i = 0; i < ATT_ENTRIES; i++) begin
            att_hits[i] = 0;
        end
        for (i = 0; i < LIST_ENTRIES; i++) begin
            list_hits[i] = 0;
        end
        att_wr_cnt  = 0;
        list_wr_cnt = 0;
    endtask

    // every entry of a region hit exactly once since the last clear
    function automatic bit region_once(input bit list_region);
        int i;
        int n;
        n = list_region ? LIST_ENTRIES : ATT_ENTRIES;
        for (i = 0; i < n; i++) begin
            if ((list_region ? list_hits[i] : att_hits[i]) != 1) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // whole att and list image against the reference
    task automatic check_image();
        int                i;
        logic [ADDR_W-1:0] a;
        for (i = 0; i < ATT_ENTRIES + LIST_ENTRIES; i++) begin
            if (i < ATT_ENTRIES) begin
                a = ATT_BASE + ADDR_W'(i);
            end else begin
                a = LIST_BASE + ADDR_W'(i - ATT_ENTRIES);
            end
            if (shadow[a] !== expected_word(a)) begin
                log_error($sformatf("image word %h is %h, expected %h",
                                    a, shadow[a], expected_word(a)));
            end
        end
    endtask

    //////////////////////////////
    // dram port monitor
    //////////////////////////////

    always @(posedge clk_i) begin
        int                       ai;
        int                       li;
        logic [ADDR_W+DATA_W-1:0] exp;
        hawk_word_u               got;
        if (rst_ni) begin
            if (cpu_gnt && !mem_we) begin
                log_error("cpu grant without a dram write");
            end
            if (mem_we && cpu_req && cpu_gnt) begin
                // cpu write, must be the oldest posted one
                cpu_wr_cnt++;
                if (cpu_q.size() == 0) begin
                    log_error($sformatf("cpu write to %h with nothing posted", mem_addr));
                end else begin
                    exp = cpu_q.pop_front();
                    if ({mem_addr, mem_wdata} !== exp) begin
                        log_error($sformatf("cpu write %h <= %h, expected %h <= %h",
                            mem_addr, mem_wdata, exp[ADDR_W+DATA_W-1:DATA_W],
                            exp[DATA_W-1:0]));
                    end
                end
            end else if (mem_we) begin
                // page writer write
                ai  = int'(mem_addr) - int'(ATT_BASE);
                li  = int'(mem_addr) - int'(LIST_BASE);
                got = mem_wdata;
                if (ai >= 0 && ai < ATT_ENTRIES) begin
                    if (list_wr_cnt != 0) begin
                        log_error($sformatf("att write to %h after list writes", mem_addr));
                    end
                    att_hits[ai]++;
                    att_wr_cnt++;
                end else if (li >= 0 && li < LIST_ENTRIES) begin
                    list_hits[li]++;
                    list_wr_cnt++;
                end else begin
                    log_error($sformatf("page writer write outside both regions at %h",
                                        mem_addr));
                end
                if (mem_wdata !== expected_word(mem_addr)) begin
                    log_error($sformatf("word at %h is %h (next %0d last %b), expected %h",
                        mem_addr, mem_wdata, got.lst.next_ptr, got.lst.last,
                        expected_word(mem_addr)));
                end
            end
            if (mem_we) begin
                shadow[mem_addr] = mem_wdata;
            end
        end
    end

endmodule

/* bench/hawk_tb.sv */
/*
 * hawk testbench
 * boot fill, cpu pass-through and free list rebuild
 * against the dram port checker
 */
`timescale 1ns/1ns

module hawk_tb
    import hawk_pkg::*;
();

    localparam int ATT_ENTRIES  = 16;
    localparam int LIST_ENTRIES = 8;
    localparam int WAIT_CYCLES  = 200;
    localparam int CPU_WRITES   = 20;

    logic              clk_i;
    logic              rst_ni;
    logic              rebuild_req;
    logic              cpu_req;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_wdata;
    logic              cpu_gnt;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;

    logic [31:0] seed;
    int          local_errs;
    int          mark;
    int          n_pass;
    int          n_fail;

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    hawk_top #(
        .ATT_ENTRIES  (ATT_ENTRIES),
        .LIST_ENTRIES (LIST_ENTRIES)
    ) u_dut (
        .clk_i(clk_i), .rst_ni(rst_ni), .rebuild_req(rebuild_req),
        .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_gnt(cpu_gnt),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    hawk_checker #(
        .ATT_ENTRIES  (ATT_ENTRIES),
        .LIST_ENTRIES (LIST_ENTRIES)
    ) u_chk (
        .clk_i(clk_i), .rst_ni(rst_ni), .cpu_req(cpu_req), .cpu_gnt(cpu_gnt),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        local_errs++;
    endtask

    function automatic int total_errs();
        return local_errs + u_chk.err_cnt;
    endfunction

    task automatic end_test(input string name);
        if (total_errs() == mark) begin
            n_pass++;
            $display("test %s ... ok", name);
        end else begin
            n_fail++;
            $display("test %s ... not ok, %0d errors", name, total_errs() - mark);
        end
        mark = total_errs();
    endtask

    task automatic post_and_drive(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        u_chk.post_cpu_write(addr, data);
        cpu_req   = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
    endtask

    // grant sampled at the falling edge
    // write lands on the next rising edge
    task automatic complete_write(input bit check_list, input string what);
        bit got;
        bit list_full;
        int n;
        got = 1'b0;
        for (n = 0; n < WAIT_CYCLES && !got; n++) begin
            @(negedge clk_i);
            got = cpu_gnt;
        end
        list_full = (u_chk.list_wr_cnt == LIST_ENTRIES) && u_chk.region_once(1'b1);
        if (!got) begin
            $display("timeout: %s did not happen within %0d cycles", what, WAIT_CYCLES);
            local_errs++;
        end else if (check_list && !list_full) begin
            mismatch("cpu granted before the free list was complete");
        end
        step();
        cpu_req = 1'b0;
        if (!got) begin
            u_chk.flush_cpu();
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [ADDR_W-1:0] a;
        bit                done;
        int                n;
        int                cpu_base;

        rst_ni      = 1'b0;
        rebuild_req = 1'b0;
        cpu_req     = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        seed        = 32'hb9c1_4b43;
        local_errs  = 0;
        n_pass      = 0;
        n_fail      = 0;
        mark        = 0;
        // cpu write already waiting while in reset
        seed = lcg_next(seed);
        post_and_drive(16'h4000, seed);
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // stray rebuild during boot must be ignored
        rebuild_req = 1'b1;
        step();
        rebuild_req = 1'b0;

        // boot fill with att region first and cpu held off
        done = 1'b0;
        for (n = 0; n < WAIT_CYCLES && !done; n++) begin
            @(negedge clk_i);
            if (cpu_gnt) begin
                mismatch("cpu_gnt high during att fill");
            end
            done = (u_chk.att_wr_cnt >= ATT_ENTRIES);
        end
        if (!done) begin
            $display("timeout: att region fill did not finish within %0d cycles", WAIT_CYCLES);
            local_errs++;
        end
        if (!u_chk.region_once(1'b0)) begin
            mismatch("att entries not written exactly once");
        end
        end_test("boot_fill");

        // free list image then the held cpu write
        complete_write(1'b1, "first cpu grant after boot");
        u_chk.check_image();
        end_test("free_list_image");

        // random cpu writes above the list region
        cpu_base = u_chk.cpu_wr_cnt;
        for (n = 0; n < CPU_WRITES; n++) begin
            seed = lcg_next(seed);
            a    = ADDR_W'(int'(LIST_BASE) + LIST_ENTRIES + int'(seed[31:20]));
            seed = lcg_next(seed);
            post_and_drive(a, seed);
            complete_write(1'b0, "cpu grant");
        end
        @(negedge clk_i);
        if (u_chk.pending() != 0 || u_chk.cpu_wr_cnt - cpu_base != CPU_WRITES) begin
            mismatch("cpu writes lost or repeated");
        end
        end_test("cpu_pass_through");

        // list rebuild from idle cpu with a write waiting behind it
        step();
        u_chk.clear_counts();
        rebuild_req = 1'b1;
        step();
        rebuild_req = 1'b0;
        seed = lcg_next(seed);
        post_and_drive(16'h5000, seed);
        complete_write(1'b1, "cpu grant after rebuild");
        if (u_chk.att_wr_cnt != 0) begin
            mismatch("att region written during list rebuild");
        end
        u_chk.check_image();
        end_test("list_rebuild");

        // rebuild in the same cycle as a granted cpu write
        u_chk.clear_counts();
        seed = lcg_next(seed);
        post_and_drive(16'h6000, seed);
        rebuild_req = 1'b1;
        @(negedge clk_i);
        if (!cpu_gnt) begin
            mismatch("cpu write not granted in the rebuild cycle");
        end
        step();
        rebuild_req = 1'b0;
        seed = lcg_next(seed);
        post_and_drive(16'h6001, seed);
        complete_write(1'b1, "cpu grant after rebuild under traffic");
        if (u_chk.att_wr_cnt != 0) begin
            mismatch("att region written during list rebuild");
        end
        u_chk.check_image();
        @(negedge clk_i);
        if (u_chk.pending() != 0) begin
            mismatch("posted cpu writes never reached dram");
        end
        end_test("rebuild_under_traffic");

        $display("summary: %0d tests ok, %0d tests not ok, %0d errors",
                 n_pass, n_fail, total_errs());
        if (n_fail == 0 && total_errs() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
src/hawk_pkg.sv
src/hawk_ctrl_unit.sv
src/hawk_pg_writer.sv
src/hawk_cpu_gate.sv
src/hawk_top.sv
bench/hawk_checker.sv
bench/hawk_tb.sv
